//--- verification/icache_golden.txt
// op (1 fetch, 2 invalidate all), byte address, expected word, expected hit flag
// All fields hex, memory word is the byte address XOR 5A5A5A5A
1 00001000 5A5A4A5A 0
1 0000100C 5A5A4A56 1
1 00001004 5A5A4A5E 1
1 00001000 5A5A4A5A 1
1 00002030 5A5A7A6A 0
1 00000018 5A5A5A42 0
1 00000024 5A5A5A7E 0
1 00003034 5A5A6A6E 0
1 00004038 5A5A1A62 0
1 0000503C 5A5A0A66 0
1 00002034 5A5A7A6E 1
1 00003030 5A5A6A6A 1
1 0000403C 5A5A1A66 1
1 00005038 5A5A0A62 1
1 0000001C 5A5A5A46 1
1 00000020 5A5A5A7A 1
1 00001008 5A5A4A52 1
2 00000000 00000000 0
1 00002030 5A5A7A6A 0
1 00001008 5A5A4A52 0
1 0000503C 5A5A0A66 0
1 00001000 5A5A4A5A 1
1 00002038 5A5A7A62 1
1 00005030 5A5A0A6A 1
1 00003030 5A5A6A6A 0
1 00003034 5A5A6A6E 1

//--- project.f
+incdir+common
common/icache_pkg.sv
icache/icacheWay.sv
icache/icacheLookup.sv
icache/icacheHitMerge.sv
hdl/icacheRefill.sv
hdl/icacheTop.sv
verification/tbClock.sv
verification/icache_asserts.sv
verification/icacheTb.sv

//--- run.sh
#!/bin/sh
# Builds the instruction cache testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f project.f \
	--top-module icacheTb -o icacheSim

# The simulator exits nonzero on a failure, the log search decides the result
./obj_dir/icacheSim > sim.log 2>&1 || true
cat sim.log

if grep -q "^Test passed$" sim.log; then
	echo "Simulation result: PASS"
else
	echo "Simulation result: FAIL"
	exit 1
fi

//--- verification/icacheTb.sv
//----------------------------------------------------------
// Instruction cache testbench
// Replays the golden operation list against the cache and
// answers its Wishbone reads from a memory model
//----------------------------------------------------------
`timescale 1ns/100ps

module icacheTb;
	import icache_pkg::*;

	// Golden lines hold four hex fields each
	localparam int maxOps = 28;
	localparam int cycleLimit = maxOps * 40;

	logic clk;
	logic rst;
	logic fetchReq = 1'b0;
	addrT fetchAdr = '0;
	logic invAll = 1'b0;
	logic fetchAck;
	logic fetchHit;
	wordT fetchData;
	logic wbCyc;
	logic wbStb;
	addrT wbAdr;
	wordT wbDat = '0;
	logic wbAck = 1'b0;

	logic [31:0] golden [maxOps * 4];
	int seed = 20;
	int busReads = 0;
	int cycleCount = 0;
	int waitLeft = 0;
	logic slaveBusy = 1'b0;

	tbClock clockInst (.clk(clk), .rst(rst));

	icacheTop icacheTop_inst (
		.clk(clk), .rst(rst), .fetchReq(fetchReq), .fetchAdr(fetchAdr),
		.invAll(invAll), .fetchAck(fetchAck), .fetchHit(fetchHit),
		.fetchData(fetchData), .wbCyc(wbCyc), .wbStb(wbStb), .wbAdr(wbAdr),
		.wbDat(wbDat), .wbAck(wbAck)
	);

	// Backing memory content is a fixed function of the byte address
	function automatic wordT memWord(input addrT adr);
		return adr ^ 32'h5A5A5A5A;
	endfunction

	task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("error at time %0t: %s is %h, expected %h", $time, what, actual, expected);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	//----------------------------------------------------------
	// Wishbone slave model
	//----------------------------------------------------------

	// Each read waits 0 to 3 cycles before its ack
	always @(posedge clk) begin : wbSlave
		int draw;
		if (rst) begin
			wbAck <= 1'b0;
			slaveBusy <= 1'b0;
			waitLeft <= 0;
		end else begin
			wbAck <= 1'b0;
			if (wbCyc && wbStb && !wbAck) begin
				// A new read draws its wait, a pending one counts down
				if (!slaveBusy)
					draw = $random(seed) & 3;
				else
					draw = waitLeft;
				if (draw == 0) begin
					wbAck <= 1'b1;
					wbDat <= memWord(wbAdr);
					busReads <= busReads + 1;
					slaveBusy <= 1'b0;
				end else begin
					slaveBusy <= 1'b1;
					waitLeft <= draw - 1;
				end
			end
		end
	end

	// Guards against a DUT that never answers
	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("Run did not finish within %0d cycles", cycleLimit);
			$display("Test failed");
			$fatal(1);
		end
	end

	//----------------------------------------------------------
	// Operations
	//----------------------------------------------------------

	// One fetch, held until the ack, then a check of word, hit and bus reads
	task automatic runFetch(input addrT adr, input wordT expWord, input logic expHit);
		int readsBefore;
		readsBefore = busReads;
		@(posedge clk);
		fetchReq <= 1'b1;
		fetchAdr <= adr;
		@(negedge clk);
		while (!fetchAck)
			@(negedge clk);
		checkValue(fetchData, expWord, "fetch data");
		checkValue({31'b0, fetchHit}, {31'b0, expHit}, "fetch hit flag");
		checkValue(busReads - readsBefore, expHit ? 32'd0 : 32'd4, "bus read count");
		@(posedge clk);
		fetchReq <= 1'b0;
	endtask

	// Single-cycle invalidate-all with the fetch port quiet
	task automatic pulseInvalidate();
		@(posedge clk);
		invAll <= 1'b1;
		@(posedge clk);
		invAll <= 1'b0;
	endtask

	initial begin : mainSeq
		int n;
		int op;
		int opsRun;
		opsRun = 0;
		for (n = 0; n < maxOps * 4; n++)
			golden[n] = '0;
		$readmemh("verification/icache_golden.txt", golden);
		@(posedge clk);
		while (rst)
			@(posedge clk);
		// Opcode zero marks unused entries past the end of the file
		for (n = 0; n < maxOps; n++) begin
			op = golden[4 * n];
			if (op == 1) begin
				runFetch(golden[4 * n + 1], golden[4 * n + 2], golden[4 * n + 3][0]);
				opsRun++;
			end else if (op == 2) begin
				pulseInvalidate();
				opsRun++;
			end else if (op != 0) begin
				$display("Golden line %0d has an unknown operation code %0d", n, op);
				$display("Test failed");
				$fatal(1);
			end
		end
		if (opsRun == 0) begin
			$display("No operations were read from the golden file");
			$display("Test failed");
			$fatal(1);
		end else begin
			$display("Test passed");
			$finish;
		end
	end

endmodule

//--- verification/icache_asserts.sv
//----------------------------------------------------------
// Instruction cache assertions
// Watches the Wishbone and fetch handshakes of the refill
// engine and the way hits that feed the merge
//----------------------------------------------------------
`timescale 1ns/100ps
`include "icache_params.svh"

module icacheAsserts (
	input logic                  clk,
	input logic                  rst,
	input logic                  wbCyc,
	input logic                  wbStb,
	input logic                  wbAck,
	input logic                  fetchAck,
	input icache_pkg::wayResultS ways [`ICACHE_WAYS]
);

	logic [`ICACHE_WAYS-1:0] hitVec;

	// Gather the per-way hit flags into one vector
	always_comb begin
		for (int i = 0; i < `ICACHE_WAYS; i++)
			hitVec[i] = ways[i].hit;
	end

	// A strobe that is not yet acked must still be there next cycle
	stbHold: assert property (@(posedge clk) disable iff (rst)
		wbStb && !wbAck |=> wbStb) else $error("wbStb dropped before wbAck");

	// Single reads only, so cyc and stb both fall the cycle after the ack
	cycStbDrop: assert property (@(posedge clk) disable iff (rst)
		wbCyc && wbAck |=> !wbCyc && !wbStb) else $error("wbCyc or wbStb high after wbAck");

	// A line lives in one way, so at most one way may hit
	oneHit: assert property (@(posedge clk) disable iff (rst)
		$onehot0(hitVec)) else $error("more than one way hits");

	// Each answer is a single-cycle pulse
	ackPulse: assert property (@(posedge clk) disable iff (rst)
		fetchAck |=> !fetchAck) else $error("fetchAck high for two cycles");

endmodule

// The top level sees both the refill port signals and the merge inputs
bind icacheTop icacheAsserts assertsInst (
	.clk(clk), .rst(rst), .wbCyc(wbCyc), .wbStb(wbStb), .wbAck(wbAck),
	.fetchAck(fetchAck), .ways(wayResults)
);

//--- verification/tbClock.sv
//----------------------------------------------------------
// Testbench clock and reset
// 10 ns clock and a synchronous reset held for 8 cycles
//----------------------------------------------------------
`timescale 1ns/100ps

module tbClock (
	output logic clk,
	output logic rst
);

	// Free-running clock, 5 ns high and 5 ns low
	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Reset drops on a rising edge so the DUT sees a clean release
	initial begin
		rst = 1'b1;
		repeat (8) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

//--- hdl/icacheTop.sv
//----------------------------------------------------------
// Instruction cache top level
// Four-way set associative cache with a Wishbone classic
// master port for line refills
//----------------------------------------------------------
`timescale 1ns/100ps
`include "icache_params.svh"

module icacheTop (
	input  logic             clk,
	input  logic             rst,
	input  logic             fetchReq,
	input  icache_pkg::addrT fetchAdr,
	input  logic             invAll,
	output logic             fetchAck,
	output logic             fetchHit,
	output icache_pkg::wordT fetchData,
	output logic             wbCyc,
	output logic             wbStb,
	output icache_pkg::addrT wbAdr,
	input  icache_pkg::wordT wbDat,
	input  logic             wbAck
);
	import icache_pkg::*;

	wayLookupS lookup;
	wayMaskT wayWe;
	wayWriteS wayWrite;
	wayResultS wayResults [`ICACHE_WAYS];
	logic anyHit;
	wordT hitData;
	logic refillWrite;
	wordT refillData;
	wordSelT refillWordSel;
	logic lineDone;

	icacheLookup lookupInst (
		.clk(clk), .rst(rst), .fetchAdr(fetchAdr),
		.refillWrite(refillWrite), .refillData(refillData),
		.refillWordSel(refillWordSel), .lineDone(lineDone),
		.lookup(lookup), .wayWe(wayWe), .wayWrite(wayWrite)
	);

	// All ways see the same lookup and refill word, the write enable picks one
	for (genvar g = 0; g < `ICACHE_WAYS; g++) begin : genWay
		icacheWay wayInst (
			.clk(clk), .rst(rst), .invAll(invAll), .lookup(lookup),
			.we(wayWe[g]), .write(wayWrite), .result(wayResults[g])
		);
	end

	icacheHitMerge hitMergeInst (
		.ways(wayResults), .anyHit(anyHit), .hitData(hitData)
	);

	icacheRefill refillInst (
		.clk(clk), .rst(rst), .fetchReq(fetchReq), .fetchAdr(fetchAdr),
		.anyHit(anyHit), .hitData(hitData),
		.fetchAck(fetchAck), .fetchHit(fetchHit), .fetchData(fetchData),
		.wbCyc(wbCyc), .wbStb(wbStb), .wbAdr(wbAdr), .wbDat(wbDat), .wbAck(wbAck),
		.refillWrite(refillWrite), .refillData(refillData),
		.refillWordSel(refillWordSel), .lineDone(lineDone)
	);

endmodule

//--- hdl/icacheRefill.sv
//----------------------------------------------------------
// Instruction cache refill engine
// Answers fetches on a hit and loads a missing line through
// single Wishbone classic reads, one per word
//----------------------------------------------------------
`timescale 1ns/100ps

module icacheRefill (
	input  logic                clk,
	input  logic                rst,
	input  logic                fetchReq,
	input  icache_pkg::addrT    fetchAdr,
	input  logic                anyHit,
	input  icache_pkg::wordT    hitData,
	output logic                fetchAck,
	output logic                fetchHit,
	output icache_pkg::wordT    fetchData,
	output logic                wbCyc,
	output logic                wbStb,
	output icache_pkg::addrT    wbAdr,
	input  icache_pkg::wordT    wbDat,
	input  logic                wbAck,
	output logic                refillWrite,
	output icache_pkg::wordT    refillData,
	output icache_pkg::wordSelT refillWordSel,
	output logic                lineDone
);
	import icache_pkg::*;

	refillStateE state;
	wordSelT wordCnt;
	logic hitAccept;

	// A new request is taken only when the last answer is not still on the port
	assign hitAccept = (state == idle) && fetchReq && !fetchAck && anyHit;

	// Bus strobes follow the wait state, so they fall the cycle after ack
	assign wbCyc = (state == waitAck);
	assign wbStb = (state == waitAck);

	// Each acked word goes straight to the victim way on the ack edge
	assign refillWrite = wbCyc && wbAck;
	assign refillData = wbDat;
	assign refillWordSel = wordCnt;
	assign lineDone = refillWrite && (wordCnt == '1);

	//----------------------------------------------------------
	// Refill FSM
	//----------------------------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= idle;
			wordCnt <= '0;
			fetchAck <= 1'b0;
			fetchHit <= 1'b0;
		end else begin
			fetchAck <= 1'b0;
			case (state)
				idle: begin
					if (hitAccept) begin
						fetchAck <= 1'b1;
						fetchHit <= 1'b1;
					end else if (fetchReq && !fetchAck) begin
						state <= busCycle;
					end
				end
				busCycle: state <= waitAck;
				waitAck: begin
					// The counter wraps back to zero with the last word
					if (wbAck) begin
						wordCnt <= wordCnt + 1'b1;
						state <= lineDone ? done : busCycle;
					end
				end
				done: begin
					// Line is valid now, the merge already shows the word
					fetchAck <= 1'b1;
					fetchHit <= 1'b0;
					state <= idle;
				end
				default: state <= idle;
			endcase
		end
	end

	// Answer word and bus address
	always_ff @(posedge clk) begin
		if (hitAccept || state == done)
			fetchData <= hitData;
		if (state == busCycle)
			wbAdr <= {fetchAdr[$bits(addrT)-1:byteOfsW + wordSelW], wordCnt, {byteOfsW{1'b0}}};
	end

endmodule

//--- icache/icacheHitMerge.sv
//----------------------------------------------------------
// Instruction cache hit merge
// Combines the per-way results into one hit flag and the
// instruction word of the hitting way
//----------------------------------------------------------
`timescale 1ns/100ps
`include "icache_params.svh"

module icacheHitMerge (
	input  icache_pkg::wayResultS ways [`ICACHE_WAYS],
	output logic                  anyHit,
	output icache_pkg::wordT      hitData
);

	// Scan from the top way down so the lowest hitting way ends up selected
	// A line lives in one way only, so in practice at most one way hits
	always_comb begin
		anyHit = 1'b0;
		hitData = '0;
		for (int i = `ICACHE_WAYS - 1; i >= 0; i--) begin
			anyHit = anyHit | ways[i].hit;
			if (ways[i].hit)
				hitData = ways[i].data;
		end
	end

endmodule

//--- icache/icacheLookup.sv
//----------------------------------------------------------
// Instruction cache lookup and victim select
// Splits the fetch address, keeps the replacement LFSR and
// steers refill words into the victim way
//----------------------------------------------------------
`timescale 1ns/100ps

module icacheLookup (
	input  logic                  clk,
	input  logic                  rst,
	input  icache_pkg::addrT      fetchAdr,
	input  logic                  refillWrite,
	input  icache_pkg::wordT      refillData,
	input  icache_pkg::wordSelT   refillWordSel,
	input  logic                  lineDone,
	output icache_pkg::wayLookupS lookup,
	output icache_pkg::wayMaskT   wayWe,
	output icache_pkg::wayWriteS  wayWrite
);
	import icache_pkg::*;

	// Any nonzero seed works for the LFSR
	localparam logic [15:0] lfsrSeed = 16'hACE1;

	logic [15:0] lfsr;
	logic feedback;
	logic [1:0] victim;

	// Address split, byte offset at the bottom is ignored
	always_comb begin
		lookup.tag = fetchAdr[$bits(addrT)-1 -: tagW];
		lookup.set = fetchAdr[byteOfsW + wordSelW +: setW];
		lookup.wordSel = fetchAdr[byteOfsW +: wordSelW];
	end

	//----------------------------------------------------------
	// Replacement LFSR
	//----------------------------------------------------------

	// Taps 16, 14, 13 and 11 give a maximal length sequence
	assign feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

	// Steps only once per loaded line so the victim holds for a whole refill
	always_ff @(posedge clk) begin
		if (rst)
			lfsr <= lfsrSeed;
		else if (lineDone)
			lfsr <= {lfsr[14:0], feedback};
	end

	assign victim = lfsr[1:0];

	// Refill word goes to every way, only the victim gets a write enable
	// The line address comes from the fetch address, held steady during the miss
	always_comb begin
		wayWrite.tag = lookup.tag;
		wayWrite.set = lookup.set;
		wayWrite.wordSel = refillWordSel;
		wayWrite.data = refillData;
		wayWrite.lastWord = lineDone;
		wayWe = refillWrite ? (wayMaskT'(1) << victim) : '0;
	end

endmodule

//--- icache/icacheWay.sv
//----------------------------------------------------------
// Instruction cache way
// Tag, valid and data storage for one way of the cache with
// an asynchronous read port and its own tag compare
//----------------------------------------------------------
`timescale 1ns/100ps
`include "icache_params.svh"

module icacheWay (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  invAll,
	input  icache_pkg::wayLookupS lookup,
	input  logic                  we,
	input  icache_pkg::wayWriteS  write,
	output icache_pkg::wayResultS result
);
	import icache_pkg::*;

	// One tag and one valid bit per set
	tagT tagMem [`ICACHE_SETS];
	logic [`ICACHE_SETS-1:0] validBits;

	// Line data, indexed by set and word within the line
	wordT dataMem [`ICACHE_SETS * `ICACHE_LINE_WORDS];

	//----------------------------------------------------------
	// Valid bits
	//----------------------------------------------------------

	// The valid bit only goes up once the whole line is in place
	// An invalidate-all wins over any write in the same cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			validBits <= '0;
		end else if (invAll) begin
			validBits <= '0;
		end else if (we && write.lastWord) begin
			validBits[write.set] <= 1'b1;
		end
	end

	//----------------------------------------------------------
	// Tag and data arrays
	//----------------------------------------------------------

	// Every refill word lands in the data array
	// The tag is written together with the last word of the line
	always_ff @(posedge clk) begin
		if (we) begin
			dataMem[{write.set, write.wordSel}] <= write.data;
			if (write.lastWord)
				tagMem[write.set] <= write.tag;
		end
	end

	// Read side is combinational, like a distributed RAM
	// The hit needs both the valid bit and a matching tag
	always_comb begin
		result.hit = validBits[lookup.set] && (tagMem[lookup.set] == lookup.tag);
		result.data = dataMem[{lookup.set, lookup.wordSel}];
	end

endmodule

//--- common/icache_pkg.sv
//----------------------------------------------------------
// Instruction cache types
// Vector types, way structs and the refill FSM encoding used
// across the cache blocks
//----------------------------------------------------------
`include "icache_params.svh"

package icache_pkg;

	// Field widths of a fetch address, low bits first
	localparam int byteOfsW = $clog2(`ICACHE_WORD_W / 8);
	localparam int wordSelW = $clog2(`ICACHE_LINE_WORDS);
	localparam int setW = $clog2(`ICACHE_SETS);
	localparam int tagW = `ICACHE_ADR_W - setW - wordSelW - byteOfsW;

	typedef logic [`ICACHE_ADR_W-1:0] addrT;
	typedef logic [`ICACHE_WORD_W-1:0] wordT;
	typedef logic [tagW-1:0] tagT;
	typedef logic [setW-1:0] setIdxT;
	typedef logic [wordSelW-1:0] wordSelT;
	typedef logic [`ICACHE_WAYS-1:0] wayMaskT;

	// Decoded fetch address, seen by every way at once
	typedef struct packed {
		tagT tag;
		setIdxT set;
		wordSelT wordSel;
	} wayLookupS;

	// One refill word; lastWord also commits the tag and valid bit
	typedef struct packed {
		tagT tag;
		setIdxT set;
		wordSelT wordSel;
		wordT data;
		logic lastWord;
	} wayWriteS;

	// Answer of a single way
	typedef struct packed {
		logic hit;
		wordT data;
	} wayResultS;

	typedef enum logic [1:0] {idle, busCycle, waitAck, done} refillStateE;

endpackage

//--- common/icache_params.svh
//----------------------------------------------------------
// Instruction cache parameters
// Address and word widths plus the cache geometry
//----------------------------------------------------------
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// Width of a byte address on the fetch side and on the bus
`define ICACHE_ADR_W 32

// Width of one instruction word, also the bus data width
`define ICACHE_WORD_W 32

// Number of sets in each way
`define ICACHE_SETS 16

// Number of ways, one icacheWay instance each
`define ICACHE_WAYS 4

// Words per cache line, so a line is sixteen bytes
`define ICACHE_LINE_WORDS 4

`endif
